/* hdl/ao_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// always-on controller constants
// bus widths, register map, power settle time, reset values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef AO_PARAMS_SVH
`define AO_PARAMS_SVH

`define AO_DATA_W 32
`define AO_ADDR_W 12

// register map, byte offsets
`define AO_REG_PWR_CTRL   12'h000
`define AO_REG_PWR_STATUS 12'h004
`define AO_REG_MTIMECMP   12'h008
`define AO_REG_MTIME      12'h00C
`define AO_REG_IRQ_EN     12'h010
`define AO_REG_IRQ_PEND   12'h014
`define AO_REG_SW_IRQ     12'h018

// cycles after switch ack before domain reset is released
`define AO_PWR_SETTLE_CYCLES 8

`define AO_MTIMECMP_RESET 32'hFFFF_FFFF
`define AO_FAST_IRQ_N     15

`endif

/* hdl/ao_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// always-on controller types
// interrupt word layout, sequencer states, AXI responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ao_params.svh"

package ao_pkg;

  // standard machine interrupt layout
  typedef struct packed {
    logic                      rsvd_31;
    logic [`AO_FAST_IRQ_N-1:0] fast;
    logic [3:0]                rsvd_15_12;
    logic                      ext;
    logic [2:0]                rsvd_10_8;
    logic                      timer;
    logic [2:0]                rsvd_6_4;
    logic                      sw;
    logic [2:0]                rsvd_2_0;
  } intr_fields_t;

  typedef union packed {
    logic [`AO_DATA_W-1:0] raw;
    intr_fields_t          fld;
  } intr_word_u;

  typedef enum logic [3:0] {
    ON, CLK_OFF, ISO_ON, RST_ON, SW_OFF, WAIT_ACK_OFF, OFF,
    SW_ON, WAIT_ACK_ON, SETTLE, RST_OFF, ISO_OFF, CLK_ON
  } pwr_state_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

/* hdl/ao_reg_axil.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite register block of the always-on controller
// holds control registers and returns status, one access at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ao_params.svh"

module ao_reg_axil (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`AO_ADDR_W-1:0]   s_awaddr_i,
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  logic [`AO_DATA_W-1:0]   s_wdata_i,
  input  logic [`AO_DATA_W/8-1:0] s_wstrb_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  output logic [1:0]              s_bresp_o,
  output logic                    s_bvalid_o,
  input  logic                    s_bready_i,
  input  logic [`AO_ADDR_W-1:0]   s_araddr_i,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  output logic [`AO_DATA_W-1:0]   s_rdata_o,
  output logic [1:0]              s_rresp_o,
  output logic                    s_rvalid_o,
  input  logic                    s_rready_i,
  input  logic                    pd_on_i,
  input  logic                    pd_busy_i,
  input  logic [`AO_DATA_W-1:0]   mtime_i,
  input  ao_pkg::intr_word_u      irq_pending_i,
  output logic                    pd_off_req_o,
  output logic [`AO_DATA_W-1:0]   mtimecmp_o,
  output logic [`AO_DATA_W-1:0]   irq_enable_o,
  output logic                    sw_irq_o
);

  import ao_pkg::*;

  logic                  wr_fire;
  logic                  rd_fire;
  logic                  wr_err;
  logic                  rd_err;
  logic [`AO_DATA_W-1:0] rd_mux;
  logic                  bvalid_q;
  axi_resp_e             bresp_q;
  logic                  rvalid_q;
  axi_resp_e             rresp_q;
  logic [`AO_DATA_W-1:0] rdata_q;

  // a pending response blocks the next transfer on that channel
  assign wr_fire     = s_awvalid_i && s_wvalid_i && !bvalid_q;
  assign rd_fire     = s_arvalid_i && !rvalid_q;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;
  assign s_arready_o = !rvalid_q;

  // only whole-word writes, s_wstrb_i has no effect
  always_comb begin
    case (s_awaddr_i)
      `AO_REG_PWR_CTRL,
      `AO_REG_MTIMECMP,
      `AO_REG_IRQ_EN,
      `AO_REG_SW_IRQ: wr_err = 1'b0;
      default:        wr_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pd_off_req_o <= 1'b0;
      mtimecmp_o   <= `AO_MTIMECMP_RESET;
      irq_enable_o <= '0;
      sw_irq_o     <= 1'b0;
    end else if (wr_fire) begin
      case (s_awaddr_i)
        `AO_REG_PWR_CTRL: pd_off_req_o <= s_wdata_i[0];
        `AO_REG_MTIMECMP: mtimecmp_o   <= s_wdata_i;
        `AO_REG_IRQ_EN:   irq_enable_o <= s_wdata_i;
        `AO_REG_SW_IRQ:   sw_irq_o     <= s_wdata_i[0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (s_bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= wr_err ? SLVERR : OKAY;
    end
  end

  // read mux, zero data on error
  always_comb begin
    rd_mux = '0;
    rd_err = 1'b0;
    case (s_araddr_i)
      `AO_REG_PWR_CTRL:   rd_mux = {{(`AO_DATA_W-1){1'b0}}, pd_off_req_o};
      `AO_REG_PWR_STATUS: rd_mux = {{(`AO_DATA_W-2){1'b0}}, pd_busy_i, pd_on_i};
      `AO_REG_MTIMECMP:   rd_mux = mtimecmp_o;
      `AO_REG_MTIME:      rd_mux = mtime_i;
      `AO_REG_IRQ_EN:     rd_mux = irq_enable_o;
      `AO_REG_IRQ_PEND:   rd_mux = irq_pending_i.raw;
      `AO_REG_SW_IRQ:     rd_mux = {{(`AO_DATA_W-1){1'b0}}, sw_irq_o};
      default:            rd_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= rd_mux;
      rresp_q <= rd_err ? SLVERR : OKAY;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rresp_o  = rresp_q;
  assign s_rdata_o  = rdata_q;

endmodule

/* hdl/pwr_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power sequencer for the switchable peripheral domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ao_params.svh"

module pwr_sequencer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic pd_off_req_i,
  input  logic pwrgate_ack_n_i,
  output logic pwrgate_en_n_o,
  output logic isogate_en_n_o,
  output logic pd_rst_n_o,
  output logic clkgate_en_n_o,
  output logic pd_on_o,
  output logic pd_busy_o
);

  import ao_pkg::*;

  localparam int SETTLE_W = $clog2(`AO_PWR_SETTLE_CYCLES + 1);

  pwr_state_e          state_q;
  pwr_state_e          state_d;
  logic [SETTLE_W-1:0] settle_cnt_q;
  logic                settle_done;
  // {pwrgate, isogate, rst, clkgate}, all active low
  logic [3:0]          ctrl_d;

  assign settle_done = (settle_cnt_q == SETTLE_W'(`AO_PWR_SETTLE_CYCLES - 1));

  // requests are only looked at in the two idle states
  always_comb begin
    state_d = state_q;
    case (state_q)
      ON:           if (pd_off_req_i) state_d = CLK_OFF;
      CLK_OFF:      state_d = ISO_ON;
      ISO_ON:       state_d = RST_ON;
      RST_ON:       state_d = SW_OFF;
      SW_OFF:       state_d = WAIT_ACK_OFF;
      WAIT_ACK_OFF: if (!pwrgate_ack_n_i) state_d = OFF;
      OFF:          if (!pd_off_req_i) state_d = SW_ON;
      SW_ON:        state_d = WAIT_ACK_ON;
      WAIT_ACK_ON:  if (pwrgate_ack_n_i) state_d = SETTLE;
      SETTLE:       if (settle_done) state_d = RST_OFF;
      RST_OFF:      state_d = ISO_OFF;
      ISO_OFF:      state_d = CLK_ON;
      CLK_ON:       state_d = ON;
      default:      state_d = ON;
    endcase
  end

  // control levels for the state being entered
  always_comb begin
    case (state_d)
      CLK_OFF:                           ctrl_d = 4'b1110;
      ISO_ON:                            ctrl_d = 4'b1010;
      RST_ON:                            ctrl_d = 4'b1000;
      SW_OFF, WAIT_ACK_OFF, OFF:         ctrl_d = 4'b0000;
      SW_ON, WAIT_ACK_ON, SETTLE:        ctrl_d = 4'b1000;
      RST_OFF:                           ctrl_d = 4'b1010;
      ISO_OFF:                           ctrl_d = 4'b1110;
      default:                           ctrl_d = 4'b1111;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q        <= ON;
      pwrgate_en_n_o <= 1'b1;
      isogate_en_n_o <= 1'b1;
      pd_rst_n_o     <= 1'b1;
      clkgate_en_n_o <= 1'b1;
      pd_on_o        <= 1'b1;
      pd_busy_o      <= 1'b0;
    end else begin
      state_q        <= state_d;
      pwrgate_en_n_o <= ctrl_d[3];
      isogate_en_n_o <= ctrl_d[2];
      pd_rst_n_o     <= ctrl_d[1];
      clkgate_en_n_o <= ctrl_d[0];
      pd_on_o        <= (state_d == ON);
      pd_busy_o      <= !(state_d inside {ON, OFF});
    end
  end

  // settle count, restarts every time SETTLE is entered
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      settle_cnt_q <= '0;
    end else if (state_q == SETTLE) begin
      settle_cnt_q <= settle_cnt_q + 1'b1;
    end else begin
      settle_cnt_q <= '0;
    end
  end

endmodule

/* hdl/ao_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine timer with compare interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ao_params.svh"

module ao_timer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`AO_DATA_W-1:0] mtimecmp_i,
  output logic [`AO_DATA_W-1:0] mtime_o,
  output logic                  timer_irq_o
);

  logic cmp_hit;

  // unsigned compare, level stays up until mtimecmp moves ahead
  assign cmp_hit = (mtime_o >= mtimecmp_i);

  // free running, wraps at the top
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_o <= '0;
    end else begin
      mtime_o <= mtime_o + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= cmp_hit;
    end
  end

endmodule

/* hdl/irq_aggregator.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interrupt aggregator
// packs sources into the machine interrupt word, masks, picks lowest id
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ao_params.svh"

module irq_aggregator (
  input  logic                      sw_irq_i,
  input  logic                      timer_irq_i,
  input  logic                      ext_irq_i,
  input  logic [`AO_FAST_IRQ_N-1:0] fast_irq_i,
  input  logic [`AO_DATA_W-1:0]     irq_enable_i,
  output ao_pkg::intr_word_u        irq_pending_o,
  output logic                      irq_o,
  output logic [4:0]                irq_id_o
);

  import ao_pkg::*;

  intr_word_u intr_raw;

  // reserved bits stay zero
  always_comb begin
    intr_raw           = '0;
    intr_raw.fld.sw    = sw_irq_i;
    intr_raw.fld.timer = timer_irq_i;
    intr_raw.fld.ext   = ext_irq_i;
    intr_raw.fld.fast  = fast_irq_i;
    irq_pending_o.raw  = intr_raw.raw & irq_enable_i;
  end

  assign irq_o = |irq_pending_o.raw;

  // scan down so the lowest set bit wins
  always_comb begin
    irq_id_o = '0;
    for (int i = `AO_DATA_W - 1; i >= 0; i--) begin
      if (irq_pending_o.raw[i]) begin
        irq_id_o = 5'(i);
      end
    end
  end

endmodule

/* hdl/ao_ctrl_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// always-on controller top level
// register block, power sequencer, machine timer, interrupt packing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ao_params.svh"

module ao_ctrl_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`AO_ADDR_W-1:0]     s_awaddr_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  input  logic [`AO_DATA_W-1:0]     s_wdata_i,
  input  logic [`AO_DATA_W/8-1:0]   s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  output logic [1:0]                s_bresp_o,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  input  logic [`AO_ADDR_W-1:0]     s_araddr_i,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  output logic [`AO_DATA_W-1:0]     s_rdata_o,
  output logic [1:0]                s_rresp_o,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  input  logic                      ext_irq_i,
  input  logic [`AO_FAST_IRQ_N-1:0] fast_irq_i,
  input  logic                      pwrgate_ack_n_i,
  output logic                      pwrgate_en_n_o,
  output logic                      isogate_en_n_o,
  output logic                      pd_rst_n_o,
  output logic                      clkgate_en_n_o,
  output logic                      irq_o,
  output logic [4:0]                irq_id_o
);

  import ao_pkg::*;

  logic                  pd_off_req;
  logic                  pd_on;
  logic                  pd_busy;
  logic [`AO_DATA_W-1:0] mtimecmp;
  logic [`AO_DATA_W-1:0] mtime;
  logic [`AO_DATA_W-1:0] irq_enable;
  logic                  sw_irq;
  logic                  timer_irq;
  intr_word_u            irq_pending;

  ao_reg_axil ao_reg_axil_i (
    .clk_i,
    .rst_n_i,
    .s_awaddr_i,
    .s_awvalid_i,
    .s_awready_o,
    .s_wdata_i,
    .s_wstrb_i,
    .s_wvalid_i,
    .s_wready_o,
    .s_bresp_o,
    .s_bvalid_o,
    .s_bready_i,
    .s_araddr_i,
    .s_arvalid_i,
    .s_arready_o,
    .s_rdata_o,
    .s_rresp_o,
    .s_rvalid_o,
    .s_rready_i,
    .pd_on_i      (pd_on),
    .pd_busy_i    (pd_busy),
    .mtime_i      (mtime),
    .irq_pending_i(irq_pending),
    .pd_off_req_o (pd_off_req),
    .mtimecmp_o   (mtimecmp),
    .irq_enable_o (irq_enable),
    .sw_irq_o     (sw_irq)
  );

  pwr_sequencer pwr_sequencer_i (
    .clk_i,
    .rst_n_i,
    .pd_off_req_i(pd_off_req),
    .pwrgate_ack_n_i,
    .pwrgate_en_n_o,
    .isogate_en_n_o,
    .pd_rst_n_o,
    .clkgate_en_n_o,
    .pd_on_o     (pd_on),
    .pd_busy_o   (pd_busy)
  );

  ao_timer ao_timer_i (
    .clk_i,
    .rst_n_i,
    .mtimecmp_i (mtimecmp),
    .mtime_o    (mtime),
    .timer_irq_o(timer_irq)
  );

  irq_aggregator irq_aggregator_i (
    .sw_irq_i     (sw_irq),
    .timer_irq_i  (timer_irq),
    .ext_irq_i,
    .fast_irq_i,
    .irq_enable_i (irq_enable),
    .irq_pending_o(irq_pending),
    .irq_o,
    .irq_id_o
  );

endmodule

/* verification/ao_ctrl_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// always-on controller checkers
// power switch ordering and AXI4-Lite response hold rules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ao_ctrl_asserts (
  input logic clk_i,
  input logic rst_n_i,
  input logic pwrgate_en_n_i,
  input logic isogate_en_n_i,
  input logic pd_rst_n_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // switch opens only behind isolation and domain reset
  pwr_off_behind_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(pwrgate_en_n_i) |-> (!isogate_en_n_i && !pd_rst_n_i))
    else $error("power switch turned off while isolation or domain reset was released");

  iso_release_on_power: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(isogate_en_n_i) |-> pwrgate_en_n_i)
    else $error("isolation released while the power switch was still off");

  bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (bvalid_i && !bready_i) |=> bvalid_i)
    else $error("write response dropped before bready");

  rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rvalid_i && !rready_i) |=> rvalid_i)
    else $error("read response dropped before rready");

endmodule

// sequencer side, bus inputs tied off
bind pwr_sequencer ao_ctrl_asserts seq_asserts (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .pwrgate_en_n_i(pwrgate_en_n_o),
  .isogate_en_n_i(isogate_en_n_o),
  .pd_rst_n_i    (pd_rst_n_o),
  .bvalid_i      (1'b0),
  .bready_i      (1'b1),
  .rvalid_i      (1'b0),
  .rready_i      (1'b1)
);

bind ao_reg_axil ao_ctrl_asserts axil_asserts (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .pwrgate_en_n_i(1'b1),
  .isogate_en_n_i(1'b1),
  .pd_rst_n_i    (1'b1),
  .bvalid_i      (s_bvalid_o),
  .bready_i      (s_bready_i),
  .rvalid_i      (s_rvalid_o),
  .rready_i      (s_rready_i)
);

/* verification/ao_ctrl_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// always-on controller testbench
// AXI4-Lite driver, power switch ack model, table of checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "ao_params.svh"

module ao_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int         CLK_PERIOD        = 4;
  localparam int         RESET_CYCLES      = 10;
  localparam int         STEP_BOUND_CYCLES = 300;
  localparam int         TIMER_WAIT_CYCLES = 40;
  localparam int         MAX_POLLS         = 64;
  localparam logic [1:0] RESP_OKAY         = 2'b00;
  localparam logic [1:0] RESP_SLVERR       = 2'b10;

  typedef enum logic [2:0] {
    OP_WR, OP_RD, OP_IDLE, OP_IRQIN, OP_PINS, OP_TIMER
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [1:0]  resp;
  } step_t;

  logic                      clk_i;
  logic                      rst_n_i;
  logic [`AO_ADDR_W-1:0]     s_awaddr_i;
  logic                      s_awvalid_i;
  logic                      s_awready_o;
  logic [`AO_DATA_W-1:0]     s_wdata_i;
  logic [`AO_DATA_W/8-1:0]   s_wstrb_i;
  logic                      s_wvalid_i;
  logic                      s_wready_o;
  logic [1:0]                s_bresp_o;
  logic                      s_bvalid_o;
  logic                      s_bready_i;
  logic [`AO_ADDR_W-1:0]     s_araddr_i;
  logic                      s_arvalid_i;
  logic                      s_arready_o;
  logic [`AO_DATA_W-1:0]     s_rdata_o;
  logic [1:0]                s_rresp_o;
  logic                      s_rvalid_o;
  logic                      s_rready_i;
  logic                      ext_irq_i;
  logic [`AO_FAST_IRQ_N-1:0] fast_irq_i;
  logic                      pwrgate_ack_n_i;
  logic                      pwrgate_en_n_o;
  logic                      isogate_en_n_o;
  logic                      pd_rst_n_o;
  logic                      clkgate_en_n_o;
  logic                      irq_o;
  logic [4:0]                irq_id_o;

  step_t       steps[$];
  logic        table_ready = 1'b0;
  logic [31:0] lfsr_q      = 32'hd063_daee;

  ao_ctrl_top dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = galois_step(lfsr_q);
      v = {v[6:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // sw at bit 3, timer at 7, ext at 11 and fast at 30..16
  function automatic logic [31:0] pack_intr(input logic sw, input logic timer,
                                            input logic ext, input logic [14:0] fast);
    logic [31:0] w;
    w = '0;
    w[3] = sw;
    w[7] = timer;
    w[11] = ext;
    w[30:16] = fast;
    return w;
  endfunction

  function automatic logic [4:0] lowest_set(input logic [31:0] w);
    for (int k = 0; k < 32; k++) begin
      if (w[k]) return 5'(k);
    end
    return 5'd0;
  endfunction

  // {irq_o, irq_id_o, pwrgate, isogate, rst, clkgate}
  function automatic logic [31:0] pins_word(input logic [3:0] ctrl, input logic [31:0] pend);
    return {22'd0, |pend, lowest_set(pend), ctrl};
  endfunction

  function automatic void add_step(input op_e op, input logic [11:0] addr,
                                   input logic [31:0] data, input logic [31:0] exp,
                                   input logic [1:0] resp);
    step_t s;
    s.op = op;
    s.addr = addr;
    s.data = data;
    s.exp = exp;
    s.resp = resp;
    steps.push_back(s);
  endfunction

  function automatic void irq_case(input logic [31:0] mask, input logic [31:0] word);
    logic [31:0] pend;
    pend = word & mask;
    add_step(OP_WR, `AO_REG_IRQ_EN, mask, 32'd0, RESP_OKAY);
    add_step(OP_RD, `AO_REG_IRQ_PEND, 32'd0, pend, RESP_OKAY);
    add_step(OP_PINS, 12'h000, 32'd0, pins_word(4'hF, pend), RESP_OKAY);
  endfunction

  function automatic void build_table();
    logic [31:0] word;
    word = pack_intr(1'b1, 1'b0, 1'b1, 15'h4024);
    // state after reset
    add_step(OP_PINS, 12'h000, 32'd0, pins_word(4'hF, 32'd0), RESP_OKAY);
    add_step(OP_RD, `AO_REG_PWR_STATUS, 32'd0, 32'd1, RESP_OKAY);
    add_step(OP_RD, `AO_REG_IRQ_EN, 32'd0, 32'd0, RESP_OKAY);
    add_step(OP_RD, `AO_REG_MTIMECMP, 32'd0, 32'hFFFF_FFFF, RESP_OKAY);
    // register readback and error responses
    add_step(OP_WR, `AO_REG_IRQ_EN, 32'h0000_0880, 32'd0, RESP_OKAY);
    add_step(OP_RD, `AO_REG_IRQ_EN, 32'd0, 32'h0000_0880, RESP_OKAY);
    add_step(OP_WR, `AO_REG_MTIMECMP, 32'h1234_5678, 32'd0, RESP_OKAY);
    add_step(OP_RD, `AO_REG_MTIMECMP, 32'd0, 32'h1234_5678, RESP_OKAY);
    add_step(OP_WR, `AO_REG_SW_IRQ, 32'd1, 32'd0, RESP_OKAY);
    add_step(OP_RD, `AO_REG_SW_IRQ, 32'd0, 32'd1, RESP_OKAY);
    add_step(OP_RD, 12'h020, 32'd0, 32'd0, RESP_SLVERR);
    add_step(OP_RD, 12'h7FC, 32'd0, 32'd0, RESP_SLVERR);
    add_step(OP_WR, `AO_REG_MTIME, 32'hDEAD_BEEF, 32'd0, RESP_SLVERR);
    add_step(OP_WR, `AO_REG_PWR_STATUS, 32'd0, 32'd0, RESP_SLVERR);
    add_step(OP_RD, `AO_REG_PWR_STATUS, 32'd0, 32'd1, RESP_OKAY);
    add_step(OP_WR, `AO_REG_SW_IRQ, 32'd0, 32'd0, RESP_OKAY);
    add_step(OP_WR, `AO_REG_IRQ_EN, 32'd0, 32'd0, RESP_OKAY);
    // domain off and on again
    add_step(OP_WR, `AO_REG_PWR_CTRL, 32'd1, 32'd0, RESP_OKAY);
    add_step(OP_IDLE, 12'h000, 32'd0, 32'd0, RESP_OKAY);
    add_step(OP_PINS, 12'h000, 32'd0, pins_word(4'h0, 32'd0), RESP_OKAY);
    add_step(OP_RD, `AO_REG_PWR_CTRL, 32'd0, 32'd1, RESP_OKAY);
    add_step(OP_WR, `AO_REG_PWR_CTRL, 32'd0, 32'd0, RESP_OKAY);
    add_step(OP_IDLE, 12'h000, 32'd0, 32'd1, RESP_OKAY);
    add_step(OP_PINS, 12'h000, 32'd0, pins_word(4'hF, 32'd0), RESP_OKAY);
    // interrupt packing and masking with ext in data bit 15
    add_step(OP_IRQIN, 12'h000, 32'h0000_C024, 32'd0, RESP_OKAY);
    add_step(OP_WR, `AO_REG_SW_IRQ, 32'd1, 32'd0, RESP_OKAY);
    irq_case(32'hFFFF_FFFF, word);
    irq_case(32'h0024_0800, word);
    irq_case(32'h4000_0000, word);
    irq_case(32'h0000_0000, word);
    // machine timer
    add_step(OP_IRQIN, 12'h000, 32'd0, 32'd0, RESP_OKAY);
    add_step(OP_WR, `AO_REG_SW_IRQ, 32'd0, 32'd0, RESP_OKAY);
    add_step(OP_WR, `AO_REG_IRQ_EN, pack_intr(1'b0, 1'b1, 1'b0, 15'd0), 32'd0, RESP_OKAY);
    add_step(OP_TIMER, 12'h000, 32'd20, 32'd7, RESP_OKAY);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t ns: %s = 0x%08h, expected 0x%08h",
                         $time, name, got, exp));
    end
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(posedge clk_i);
    s_awaddr_i  <= addr;
    s_wdata_i   <= data;
    s_awvalid_i <= 1'b1;
    s_wvalid_i  <= 1'b1;
    @(negedge clk_i);
    while (!s_awready_o) @(negedge clk_i);
    // address and data are taken together
    check_eq("s_wready_o", {31'd0, s_wready_o}, 32'd1);
    @(posedge clk_i);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    @(negedge clk_i);
    while (!s_bvalid_o) @(negedge clk_i);
    resp = s_bresp_o;
    // ready comes one cycle late so the response has to hold
    @(posedge clk_i);
    s_bready_i <= 1'b1;
    @(posedge clk_i);
    s_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk_i);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    @(negedge clk_i);
    while (!s_arready_o) @(negedge clk_i);
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    @(negedge clk_i);
    while (!s_rvalid_o) @(negedge clk_i);
    data = s_rdata_o;
    resp = s_rresp_o;
    @(posedge clk_i);
    s_rready_i <= 1'b1;
    @(posedge clk_i);
    s_rready_i <= 1'b0;
  endtask

  task automatic wait_idle(input logic [31:0] exp);
    logic [31:0] status;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    do begin
      axi_read(`AO_REG_PWR_STATUS, status, resp);
      polls++;
    end while (status[1] && polls < MAX_POLLS);
    if (status[1]) begin
      fail_run("power sequence still busy after the last status poll");
    end else begin
      check_eq("pwr_status", status, exp);
    end
  endtask

  task automatic arm_timer(input logic [31:0] offset, input logic [31:0] exp_id);
    logic [31:0] t0;
    logic [31:0] t1;
    logic [1:0]  resp;
    int          waited;
    axi_read(`AO_REG_MTIME, t0, resp);
    axi_read(`AO_REG_MTIME, t1, resp);
    check_eq("mtime_increases", {31'd0, t1 > t0}, 32'd1);
    axi_write(`AO_REG_MTIMECMP, t0 + offset, resp);
    check_eq("mtimecmp_bresp", {30'd0, resp}, {30'd0, RESP_OKAY});
    @(negedge clk_i);
    check_eq("irq_o", {31'd0, irq_o}, 32'd0);
    waited = 0;
    while (!irq_o && waited < TIMER_WAIT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!irq_o) begin
      fail_run("timer interrupt did not rise after mtime reached the compare value");
    end else begin
      check_eq("irq_id_o", {27'd0, irq_id_o}, exp_id);
    end
  endtask

  // power switch model whose ack follows the enable after 1 to 8 cycles
  always begin : switch_ack
    logic target;
    int   delay;
    @(negedge clk_i);
    if (rst_n_i && (pwrgate_en_n_o !== pwrgate_ack_n_i)) begin
      target = pwrgate_en_n_o;
      delay = int'(take_bits(3)) + 1;
      repeat (delay) @(posedge clk_i);
      pwrgate_ack_n_i <= target;
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = steps.size() * STEP_BOUND_CYCLES + RESET_CYCLES;
    repeat (limit) @(posedge clk_i);
    fail_run($sformatf("timeout: run did not finish within %0d clock cycles", limit));
  end

  initial begin : main
    logic [31:0] rdata;
    logic [1:0]  resp;
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    s_awaddr_i      = '0;
    s_awvalid_i     = 1'b0;
    s_wdata_i       = '0;
    s_wstrb_i       = '1;
    s_wvalid_i      = 1'b0;
    s_bready_i      = 1'b0;
    s_araddr_i      = '0;
    s_arvalid_i     = 1'b0;
    s_rready_i      = 1'b0;
    ext_irq_i       = 1'b0;
    fast_irq_i      = '0;
    pwrgate_ack_n_i = 1'b1;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    foreach (steps[i]) begin
      case (steps[i].op)
        OP_WR: begin
          axi_write(steps[i].addr, steps[i].data, resp);
          check_eq($sformatf("bresp[%03h]", steps[i].addr), {30'd0, resp},
                   {30'd0, steps[i].resp});
        end
        OP_RD: begin
          axi_read(steps[i].addr, rdata, resp);
          check_eq($sformatf("rresp[%03h]", steps[i].addr), {30'd0, resp},
                   {30'd0, steps[i].resp});
          check_eq($sformatf("rdata[%03h]", steps[i].addr), rdata, steps[i].exp);
        end
        OP_IDLE: wait_idle(steps[i].exp);
        OP_IRQIN: begin
          @(posedge clk_i);
          ext_irq_i  <= steps[i].data[15];
          fast_irq_i <= steps[i].data[14:0];
          @(posedge clk_i);
        end
        OP_PINS: begin
          @(negedge clk_i);
          check_eq("domain_ctrl",
                   {28'd0, pwrgate_en_n_o, isogate_en_n_o, pd_rst_n_o, clkgate_en_n_o},
                   {28'd0, steps[i].exp[3:0]});
          check_eq("irq_o", {31'd0, irq_o}, {31'd0, steps[i].exp[9]});
          check_eq("irq_id_o", {27'd0, irq_id_o}, {27'd0, steps[i].exp[8:4]});
        end
        OP_TIMER: arm_timer(steps[i].data, steps[i].exp);
        default: fail_run("table holds an unknown operation");
      endcase
    end
    $display("TEST OK");
    $finish;
  end

endmodule

/* compile.f */
+incdir+hdl
hdl/ao_pkg.sv
hdl/ao_reg_axil.sv
hdl/pwr_sequencer.sv
hdl/ao_timer.sv
hdl/irq_aggregator.sv
hdl/ao_ctrl_top.sv
verification/ao_ctrl_asserts.sv
verification/ao_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the always-on controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module ao_ctrl_tb -Mdir obj_dir -o ao_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ao_ctrl_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
